/* Bender.yml */
package:
  name: uart_bus_slave

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/slave_pkg.sv
      - src/frame_decoder.sv
      - src/write_path.sv
      - src/read_path.sv
      - src/uart_bus_slave.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_uart_bus_slave.sv

/* dv/tb_uart_bus_slave.sv */
`timescale 1ns/1ns
`include "slave_cfg.svh"

module tb_uart_bus_slave
    import slave_pkg::*;
();
    localparam int W               = `SLV_DATA_WIDTH;
    localparam int OUT_LEN         = W + 4;
    localparam int FRAME_LEN       = `SLV_START_LEN + `SLV_ID_WIDTH + 1;
    localparam int TIMEOUT         = `SLV_ACK_TIMEOUT;
    localparam int RETRIES         = `SLV_RETRANSMITS;
    localparam int CLK_PERIOD      = 100;
    localparam int NUM_TESTS       = 5;
    localparam int WRITE_LIMIT     = TIMEOUT * (RETRIES + 2) + 200;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (W + WRITE_LIMIT);
    localparam logic [`SLV_ID_WIDTH-1:0]  SLAVE_ID   = `SLV_DEFAULT_ID;
    localparam logic [`SLV_START_LEN-1:0] GOOD_START = '1;
    localparam logic [7:0] ACK_CODE    = 8'b1100_1100;
    localparam int         REPLY_ACK   = 0;
    localparam int         REPLY_OTHER = 1;
    localparam int         REPLY_NONE  = 2;

    logic     clk;
    logic     rstN;
    logic     ctrl;
    logic     wr_bit;
    logic     wr_valid;
    logic     g_tx_ready;
    logic     s_tx_ready;
    uart_rx_t g_rx;
    uart_rx_t s_rx;
    logic     rd_bit;
    logic     ready;
    uart_tx_t g_tx;
    uart_tx_t s_tx;

    int unsigned  cycle = 0;
    int           errors;
    int           errors_at_start;
    int           pass_cnt;
    int           fail_cnt;
    int           test_num;
    logic         links_quiet;
    logic [3:0]   exp_status;
    int unsigned  seed_val;
    int           g_delay;
    int           g_ack_cnt;
    logic [W-1:0] g_words[$];
    // s link model state
    int           s_mode;
    logic         s_pending;
    int           s_countdown;
    logic [W-1:0] s_reply;
    logic [W-1:0] s_words[$];
    int unsigned  s_cycles[$];

    uart_bus_slave dut0 (
        .clk       (clk),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .wr_bit    (wr_bit),
        .wr_valid  (wr_valid),
        .rd_bit    (rd_bit),
        .ready     (ready),
        .g_tx      (g_tx),
        .g_tx_ready(g_tx_ready),
        .g_rx      (g_rx),
        .s_tx      (s_tx),
        .s_tx_ready(s_tx_ready),
        .s_rx      (s_rx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic log_mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    task automatic timeout_error(input string msg);
        errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // link ready lines toggle randomly every cycle
    always @(negedge clk) begin
        g_tx_ready = ($urandom_range(0, 3) != 0);
        s_tx_ready = ($urandom_range(0, 3) != 0);
    end

    // s link records each start strobe and schedules its reply
    always @(posedge clk) begin
        if (rstN && s_tx.start) begin
            s_words.push_back(s_tx.data);
            s_cycles.push_back(cycle);
            if (s_mode != REPLY_NONE) begin
                s_reply = $urandom;
                if (s_mode == REPLY_ACK) begin
                    s_reply[7:0] = ACK_CODE;
                end else if (s_reply[7:0] == ACK_CODE) begin
                    s_reply[7:0] = ~ACK_CODE;
                end
                s_countdown = $urandom_range(0, 19);
                s_pending   = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (s_pending && s_countdown == 0) begin
            s_rx.data = s_reply;
            s_rx.done = 1'b1;
            s_pending = 1'b0;
        end else begin
            s_rx.done = 1'b0;
            if (s_pending) begin
                s_countdown--;
            end
        end
    end

    // g link supplies one word each time ready falls
    initial begin
        g_rx = '0;
        forever begin
            @(negedge ready);
            g_delay = $urandom_range(1, 20);
            repeat (g_delay) @(negedge clk);
            g_rx.data = $urandom;
            g_rx.done = 1'b1;
            g_words.push_back(g_rx.data);
            @(negedge clk);
            g_rx.done = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rstN && g_tx.start) begin
            g_ack_cnt++;
        end
        if (rstN && links_quiet) begin
            assert (!s_tx.start && !g_tx.start)
                else log_mismatch("link start strobe while no valid frame was sent");
            assert (ready)
                else log_mismatch("ready low while no valid frame was sent");
        end
    end

    ack_before_ready: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ready) |-> $past(g_tx.start))
        else log_mismatch("ready rose without a g_tx ACK strobe one cycle before");

    g_ack_code: assert property (@(posedge clk) disable iff (!rstN)
        g_tx.start |-> (g_tx.data == {{(W-8){1'b0}}, ACK_CODE}))
        else log_mismatch("g_tx strobe does not carry the ACK code");

    g_strobe_single: assert property (@(posedge clk) disable iff (!rstN)
        g_tx.start |=> !g_tx.start)
        else log_mismatch("g_tx start held longer than one cycle");

    s_strobe_single: assert property (@(posedge clk) disable iff (!rstN)
        s_tx.start |=> !s_tx.start)
        else log_mismatch("s_tx start held longer than one cycle");

    // start field, id MSB first, then read/write
    task automatic send_frame(input logic [`SLV_ID_WIDTH-1:0] id, input logic write,
                              input logic [`SLV_START_LEN-1:0] start);
        logic [FRAME_LEN-1:0] bits;
        bits = {start, id, write};
        for (int i = FRAME_LEN - 1; i >= 0; i--) begin
            @(negedge clk);
            ctrl = bits[i];
        end
        @(negedge clk);
        ctrl = 1'b0;
    endtask

    task automatic read_and_check(input logic [3:0] status);
        logic [OUT_LEN-1:0] got;
        logic [W-1:0]       word;
        int                 acks_before;
        int                 n;
        acks_before = g_ack_cnt;
        send_frame(SLAVE_ID, 1'b0, GOOD_START);
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (ready && n < 20);
        if (ready) begin
            timeout_error("ready never fell after a read frame");
            return;
        end
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!ready && n < 200);
        if (!ready) begin
            timeout_error("ready never rose again during a read");
            return;
        end
        // first bit is valid on the cycle ready reads high
        got[OUT_LEN-1] = rd_bit;
        for (int i = OUT_LEN - 2; i >= 0; i--) begin
            @(posedge clk);
            got[i] = rd_bit;
        end
        @(negedge clk);
        assert (g_words.size() == 1)
            else log_mismatch($sformatf("g link supplied %0d words", g_words.size()));
        word = (g_words.size() > 0) ? g_words.pop_front() : '0;
        assert (got == {status, word})
            else log_mismatch($sformatf("read gave %h, expected %h", got, {status, word}));
        assert (g_ack_cnt == acks_before + 1)
            else log_mismatch($sformatf("%0d g_tx strobes", g_ack_cnt - acks_before));
    endtask

    task automatic write_and_check(input int mode);
        logic [W-1:0] word;
        int           gaps;
        int           n;
        int           expected;
        word = $urandom;
        s_words.delete();
        s_cycles.delete();
        s_mode = mode;
        send_frame(SLAVE_ID, 1'b1, GOOD_START);
        for (int i = W - 1; i >= 0; i--) begin
            gaps = $urandom_range(0, 2);
            repeat (gaps) begin
                @(negedge clk);
                wr_valid = 1'b0;
                wr_bit   = 1'($urandom);
            end
            @(negedge clk);
            wr_valid = 1'b1;
            wr_bit   = word[i];
        end
        @(negedge clk);
        wr_valid = 1'b0;
        // write path busy covers the whole link exchange
        n = 0;
        while (dut0.wr_busy && n < WRITE_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (dut0.wr_busy) begin
            timeout_error("write path still busy after the whole retry budget");
        end
        @(negedge clk);
        expected = (mode == REPLY_NONE) ? RETRIES + 1 : 1;
        assert (s_words.size() == expected)
            else log_mismatch($sformatf("%0d s_tx strobes, expected %0d",
                                        s_words.size(), expected));
        foreach (s_words[k]) begin
            assert (s_words[k] == word)
                else log_mismatch($sformatf("s_tx word %h, expected %h", s_words[k], word));
            if (k > 0) begin
                assert (s_cycles[k] - s_cycles[k-1] >= TIMEOUT)
                    else log_mismatch("retransmit came before the ACK timeout");
            end
        end
        exp_status = (mode == REPLY_ACK) ? 4'b1100 : 4'b1010;
    endtask

    task automatic begin_test();
        test_num++;
        errors_at_start = errors;
    endtask

    task automatic close_test(input string name);
        if (errors == errors_at_start) begin
            pass_cnt++;
            $display("test %0d %s: passed", test_num, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: failed", test_num, name);
        end
    endtask

    initial begin
        seed_val    = $urandom(32'ha9b6);
        rstN        = 1'b0;
        ctrl        = 1'b0;
        wr_bit      = 1'b0;
        wr_valid    = 1'b0;
        g_tx_ready  = 1'b1;
        s_tx_ready  = 1'b1;
        s_rx        = '0;
        s_mode      = REPLY_NONE;
        s_pending   = 1'b0;
        s_countdown = 0;
        links_quiet = 1'b0;
        exp_status  = 4'b0000;
        errors      = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        test_num    = 0;
        g_ack_cnt   = 0;
        repeat (4) @(negedge clk);
        rstN = 1'b1;

        begin_test();
        links_quiet = 1'b1;
        repeat (6) @(negedge clk);
        links_quiet = 1'b0;
        read_and_check(exp_status);
        close_test("read after reset");

        begin_test();
        write_and_check(REPLY_ACK);
        read_and_check(exp_status);
        close_test("write with ACK reply");

        begin_test();
        write_and_check(REPLY_OTHER);
        read_and_check(exp_status);
        close_test("write with other reply");

        begin_test();
        write_and_check(REPLY_NONE);
        read_and_check(exp_status);
        close_test("write with no reply");

        // wrong id both directions, then a broken start field
        begin_test();
        links_quiet = 1'b1;
        send_frame(~SLAVE_ID, 1'b1, GOOD_START);
        repeat (8) @(negedge clk);
        send_frame(~SLAVE_ID, 1'b0, GOOD_START);
        repeat (8) @(negedge clk);
        send_frame(SLAVE_ID, 1'b1, GOOD_START << 1);
        repeat (8) @(negedge clk);
        links_quiet = 1'b0;
        read_and_check(exp_status);
        close_test("foreign and broken frames");

        $display("tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+src
src/slave_pkg.sv
src/frame_decoder.sv
src/write_path.sv
src/read_path.sv
src/uart_bus_slave.sv
dv/tb_uart_bus_slave.sv

/* src/frame_decoder.sv */
`timescale 1ns/1ns
`include "slave_cfg.svh"

module frame_decoder
    import slave_pkg::*;
#(
    parameter logic [`SLV_ID_WIDTH-1:0] SLAVE_ID = `SLV_DEFAULT_ID
) (
    input  logic clk,
    input  logic rstN,
    input  logic ctrl,
    input  logic wr_busy,
    input  logic rd_busy,
    output txn_t txn
);
    // frame layout, MSB first: start ones, slave id, read/write
    localparam int FRAME_LEN = `SLV_START_LEN + `SLV_ID_WIDTH + 1;
    localparam int CNT_W     = $clog2(FRAME_LEN + 1);

    decoder_state_e       state;
    logic [FRAME_LEN-2:0] frame_sr;
    logic [FRAME_LEN-1:0] frame_next;
    logic [CNT_W-1:0]     bit_cnt;
    logic                 hold_off;
    logic                 frame_start;
    logic                 start_ok;
    logic                 id_ok;

    // a strobe in flight counts as busy until the path raises its own flag
    assign hold_off    = wr_busy || rd_busy || txn.strobe;
    assign frame_start = (state == DEC_IDLE) && ctrl && !hold_off;

    // last bit is taken straight from ctrl so the check needs no extra cycle
    assign frame_next = {frame_sr, ctrl};
    assign start_ok   = &frame_next[FRAME_LEN-1 -: `SLV_START_LEN];
    assign id_ok      = (frame_next[`SLV_ID_WIDTH:1] == SLAVE_ID);

    always_ff @(posedge clk) begin
        if (frame_start || (state == DEC_FRAME)) begin
            frame_sr <= frame_next[FRAME_LEN-2:0];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= DEC_IDLE;
            bit_cnt <= '0;
            txn     <= '0;
        end else begin
            txn.strobe <= 1'b0;
            case (state)
                DEC_IDLE: begin
                    // first cycle with ctrl high carries bit one
                    if (frame_start) begin
                        bit_cnt <= CNT_W'(1);
                        state   <= DEC_FRAME;
                    end
                end
                DEC_FRAME: begin
                    if (bit_cnt == CNT_W'(FRAME_LEN - 1)) begin
                        bit_cnt <= '0;
                        state   <= DEC_IDLE;
                        if (start_ok && id_ok) begin
                            txn.strobe <= 1'b1;
                            txn.write  <= ctrl;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= DEC_IDLE;
                end
            endcase
        end
    end

endmodule

/* src/read_path.sv */
`timescale 1ns/1ns
`include "slave_cfg.svh"

module read_path
    import slave_pkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  txn_t       txn,
    input  uart_rx_t   g_rx,
    input  logic       g_tx_ready,
    input  wr_status_e wr_status,
    output uart_tx_t   g_tx,
    output logic       rd_bit,
    output logic       ready,
    output logic       busy
);
    // status nibble goes out ahead of the word
    localparam int OUT_LEN = `SLV_DATA_WIDTH + 4;
    localparam int CNT_W   = $clog2(OUT_LEN);

    read_state_e        state;
    logic [OUT_LEN-1:0] out_sr;
    logic [CNT_W-1:0]   out_cnt;
    logic               ack_fire;
    logic               capture;
    logic               last_bit;

    assign capture  = (state == RD_WAIT_DATA) && g_rx.done;
    assign ack_fire = (state == RD_SEND_ACK) && g_tx_ready;
    assign last_bit = (out_cnt == CNT_W'(OUT_LEN - 1));

    // reply to the sending board is always the ACK code
    assign g_tx.start = ack_fire;
    assign g_tx.data  = `SLV_DATA_WIDTH'(LINK_ACK);
    assign busy       = (state != RD_IDLE);

    always_ff @(posedge clk) begin
        if (capture) begin
            out_sr <= {wr_status, g_rx.data};
        end else if (ack_fire || (state == RD_SHIFT_OUT)) begin
            out_sr <= {out_sr[OUT_LEN-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= RD_IDLE;
            out_cnt <= '0;
            rd_bit  <= 1'b0;
            ready   <= 1'b1;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (txn.strobe && !txn.write) begin
                        ready <= 1'b0;
                        state <= RD_WAIT_DATA;
                    end
                end
                RD_WAIT_DATA: begin
                    if (capture) begin
                        state <= RD_SEND_ACK;
                    end
                end
                RD_SEND_ACK: begin
                    // first bit lines up with ready going high
                    if (ack_fire) begin
                        rd_bit  <= out_sr[OUT_LEN-1];
                        ready   <= 1'b1;
                        out_cnt <= '0;
                        state   <= RD_SHIFT_OUT;
                    end
                end
                RD_SHIFT_OUT: begin
                    if (last_bit) begin
                        rd_bit <= 1'b0;
                        state  <= RD_IDLE;
                    end else begin
                        rd_bit  <= out_sr[OUT_LEN-1];
                        out_cnt <= out_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

endmodule

/* src/slave_cfg.svh */
`ifndef SLAVE_CFG_SVH
`define SLAVE_CFG_SVH

// width of one transfer word on the master bus and on both links
`define SLV_DATA_WIDTH 32

// slave id field inside a control frame
`define SLV_ID_WIDTH 2

// id this slave answers to unless overridden at the top level
`define SLV_DEFAULT_ID 1

// cycles to wait for a link reply before sending the word again
`define SLV_ACK_TIMEOUT 64

// upper bound on retransmits of one word
`define SLV_RETRANSMITS 5

// leading ones that open every control frame
`define SLV_START_LEN 3

`endif

/* src/slave_pkg.sv */
package slave_pkg;

`include "slave_cfg.svh"

    // request towards a uart transmitter, start is a one-cycle strobe
    typedef struct packed {
        logic                       start;
        logic [`SLV_DATA_WIDTH-1:0] data;
    } uart_tx_t;

    // reply from a uart receiver, data is valid only while done is high
    typedef struct packed {
        logic                       done;
        logic [`SLV_DATA_WIDTH-1:0] data;
    } uart_rx_t;

    // decoded transaction, write set means master to link
    typedef struct packed {
        logic strobe;
        logic write;
    } txn_t;

    typedef enum logic [7:0] {
        LINK_ACK = 8'b1100_1100,
        LINK_NAK = 8'b1010_1010
    } link_code_e;

    // upper nibble of the link codes, plus the value before any write
    typedef enum logic [3:0] {
        ST_NONE = 4'b0000,
        ST_ACK  = 4'b1100,
        ST_NAK  = 4'b1010
    } wr_status_e;

    typedef enum logic {DEC_IDLE, DEC_FRAME} decoder_state_e;

    typedef enum logic [2:0] {WR_IDLE, WR_SHIFT, WR_SEND, WR_WAIT_ACK, WR_RETRY} write_state_e;

    typedef enum logic [1:0] {RD_IDLE, RD_WAIT_DATA, RD_SEND_ACK, RD_SHIFT_OUT} read_state_e;

endpackage

/* src/uart_bus_slave.sv */
`timescale 1ns/1ns
`include "slave_cfg.svh"

module uart_bus_slave
    import slave_pkg::*;
#(
    parameter logic [`SLV_ID_WIDTH-1:0] SLAVE_ID = `SLV_DEFAULT_ID
) (
    input  logic     clk,
    input  logic     rstN,
    // master side
    input  logic     ctrl,
    input  logic     wr_bit,
    input  logic     wr_valid,
    output logic     rd_bit,
    output logic     ready,
    // link that supplies read data
    output uart_tx_t g_tx,
    input  logic     g_tx_ready,
    input  uart_rx_t g_rx,
    // link that takes write data
    output uart_tx_t s_tx,
    input  logic     s_tx_ready,
    input  uart_rx_t s_rx
);
    txn_t       txn;
    logic       wr_busy;
    logic       rd_busy;
    wr_status_e wr_status;

    frame_decoder #(
        .SLAVE_ID(SLAVE_ID)
    ) u_frame_decoder (
        .clk    (clk),
        .rstN   (rstN),
        .ctrl   (ctrl),
        .wr_busy(wr_busy),
        .rd_busy(rd_busy),
        .txn    (txn)
    );

    write_path u_write_path (
        .clk       (clk),
        .rstN      (rstN),
        .txn       (txn),
        .wr_bit    (wr_bit),
        .wr_valid  (wr_valid),
        .s_tx_ready(s_tx_ready),
        .s_rx      (s_rx),
        .s_tx      (s_tx),
        .wr_status (wr_status),
        .busy      (wr_busy)
    );

    read_path u_read_path (
        .clk       (clk),
        .rstN      (rstN),
        .txn       (txn),
        .g_rx      (g_rx),
        .g_tx_ready(g_tx_ready),
        .wr_status (wr_status),
        .g_tx      (g_tx),
        .rd_bit    (rd_bit),
        .ready     (ready),
        .busy      (rd_busy)
    );

endmodule

/* src/write_path.sv */
`timescale 1ns/1ns
`include "slave_cfg.svh"

module write_path
    import slave_pkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  txn_t       txn,
    input  logic       wr_bit,
    input  logic       wr_valid,
    input  logic       s_tx_ready,
    input  uart_rx_t   s_rx,
    output uart_tx_t   s_tx,
    output wr_status_e wr_status,
    output logic       busy
);
    localparam int W     = `SLV_DATA_WIDTH;
    localparam int BIT_W = $clog2(W);
    localparam int TO_W  = $clog2(`SLV_ACK_TIMEOUT + 1);
    localparam int RT_W  = $clog2(`SLV_RETRANSMITS + 1);

    write_state_e     state;
    logic [W-1:0]     word_sr;
    logic [BIT_W-1:0] bit_cnt;
    logic [TO_W-1:0]  to_cnt;
    logic [RT_W-1:0]  retry_cnt;
    logic             shift_en;
    logic             tx_fire;

    assign shift_en = (state == WR_SHIFT) && wr_valid;

    // first send and every retransmit go out as soon as the link is ready
    assign tx_fire = ((state == WR_SEND) || (state == WR_RETRY)) && s_tx_ready;

    // word stays in the shift register, so retransmits reuse it as is
    assign s_tx.start = tx_fire;
    assign s_tx.data  = word_sr;
    assign busy       = (state != WR_IDLE);

    // master word, MSB first
    always_ff @(posedge clk) begin
        if (shift_en) begin
            word_sr <= {word_sr[W-2:0], wr_bit};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= WR_IDLE;
            bit_cnt   <= '0;
            to_cnt    <= '0;
            retry_cnt <= '0;
            wr_status <= ST_NONE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (txn.strobe && txn.write) begin
                        bit_cnt <= '0;
                        state   <= WR_SHIFT;
                    end
                end
                WR_SHIFT: begin
                    if (wr_valid) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(W - 1)) begin
                            state <= WR_SEND;
                        end
                    end
                end
                WR_SEND: begin
                    if (tx_fire) begin
                        to_cnt    <= '0;
                        retry_cnt <= '0;
                        state     <= WR_WAIT_ACK;
                    end
                end
                WR_WAIT_ACK: begin
                    if (s_rx.done) begin
                        // only the low byte carries the link code
                        if (s_rx.data[7:0] == LINK_ACK) begin
                            wr_status <= ST_ACK;
                        end else begin
                            wr_status <= ST_NAK;
                        end
                        state <= WR_IDLE;
                    end else if (to_cnt == TO_W'(`SLV_ACK_TIMEOUT - 1)) begin
                        if (retry_cnt == RT_W'(`SLV_RETRANSMITS)) begin
                            // out of retries, link never answered
                            wr_status <= ST_NAK;
                            state     <= WR_IDLE;
                        end else begin
                            state <= WR_RETRY;
                        end
                    end else begin
                        to_cnt <= to_cnt + 1'b1;
                    end
                end
                WR_RETRY: begin
                    if (tx_fire) begin
                        to_cnt    <= '0;
                        retry_cnt <= retry_cnt + 1'b1;
                        state     <= WR_WAIT_ACK;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

endmodule
